//--- verilog/axis_fan_out_pkg.sv
//////////////////////////////////////////////////
// shared widths and vector types for the fan-out
// routed beat struct, per-lane data and count buses
//////////////////////////////////////////////////

`default_nettype none

package axis_fan_out_pkg;

  //////////////////////////////////////////////////
  // widths

  // one stream word
  parameter int DATA_WIDTH  = 32;
  // output lanes, index 3 is the missing lane
  parameter int NUM_LANES   = 3;
  // lane field in the top bits of the word
  parameter int DEST_WIDTH  = 2;
  // statistics counters, wrapping
  parameter int COUNT_WIDTH = 16;

  //////////////////////////////////////////////////
  // vector types

  typedef logic [DATA_WIDTH-1:0]  data_t;
  typedef logic [DEST_WIDTH-1:0]  dest_t;
  typedef logic [NUM_LANES-1:0]   lane_mask_t;
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // beat between decode and fan-out
  typedef struct packed {
    data_t data;
    dest_t dest;
  } axis_beat_t;

  // one entry per lane
  typedef data_t  [NUM_LANES-1:0] lane_data_t;
  typedef count_t [NUM_LANES-1:0] lane_count_t;

endpackage

`default_nettype wire

//--- verilog/axis_dest_decode.sv
//////////////////////////////////////////////////
// destination decode stage
// one register slice, lane field from top bits,
// drop and strobe for beats aimed at lane 3
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module axis_dest_decode (
  input  logic                         axis_clk,
  input  logic                         rst_n,

  // stream in
  input  logic                         s_tvalid,
  output logic                         s_tready,
  input  axis_fan_out_pkg::data_t      s_tdata,

  // routed beat out
  output logic                         dec_valid,
  input  logic                         dec_ready,
  output axis_fan_out_pkg::axis_beat_t dec_beat,

  // one cycle per dropped beat
  output logic                         drop_pulse
);

  import axis_fan_out_pkg::*;

  // first lane index with no output behind it
  localparam dest_t DROP_DEST = dest_t'(NUM_LANES);

  dest_t in_dest;
  logic  in_drop;
  logic  in_fire;
  // set one cycle after reset releases
  logic  run_q;

  //////////////////////////////////////////////////
  // input side

  // lane index sits in the top bits
  assign in_dest = s_tdata[DATA_WIDTH-1 -: DEST_WIDTH];
  assign in_drop = (in_dest >= DROP_DEST);

  // accept into an empty slot or one being drained
  assign s_tready = run_q & (~dec_valid | dec_ready);
  assign in_fire  = s_tvalid & s_tready;

  always_ff @(posedge axis_clk) begin
    if (!rst_n) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // pipeline register

  always_ff @(posedge axis_clk) begin
    if (!rst_n) begin
      dec_valid  <= 1'b0;
      drop_pulse <= 1'b0;
    end else begin
      // dropped beat is consumed here, never stored
      drop_pulse <= in_fire & in_drop;
      if (in_fire && !in_drop) begin
        dec_valid <= 1'b1;
      end else if (dec_ready) begin
        dec_valid <= 1'b0;
      end
    end
  end

  // payload only loads on a kept beat
  always_ff @(posedge axis_clk) begin
    if (in_fire && !in_drop) begin
      dec_beat.data <= s_tdata;
      dec_beat.dest <= in_dest;
    end
  end

endmodule

`default_nettype wire

//--- verilog/axis_fan_out_core.sv
//////////////////////////////////////////////////
// one-to-three stream router
// valid steered by dest, ready taken from the
// addressed lane, data broadcast to all lanes
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module axis_fan_out_core (
  // routed beat in
  input  logic                         dec_valid,
  output logic                         dec_ready,
  input  axis_fan_out_pkg::axis_beat_t dec_beat,

  // per-lane links to the FIFOs
  output axis_fan_out_pkg::lane_mask_t fan_valid,
  input  axis_fan_out_pkg::lane_mask_t fan_ready,
  output axis_fan_out_pkg::data_t      fan_data
);

  import axis_fan_out_pkg::*;

  //////////////////////////////////////////////////
  // valid and ready steering

  // purely combinational, zero latency
  always_comb begin
    fan_valid = '0;
    // unknown lane never accepts
    dec_ready = 1'b0;
    for (int n = 0; n < NUM_LANES; n++) begin
      if (dec_beat.dest == dest_t'(n)) begin
        // only the addressed lane sees valid
        fan_valid[n] = dec_valid;
        // upstream stalls on that lane alone
        dec_ready    = fan_ready[n];
      end
    end
  end

  //////////////////////////////////////////////////
  // data

  // same word on every lane, valid picks the taker
  assign fan_data = dec_beat.data;

endmodule

`default_nettype wire

//--- verilog/axis_fifo_sync.sv
//////////////////////////////////////////////////
// single-clock stream FIFO
// circular memory with wrap-bit pointers and a
// registered output word, bypass when empty
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module axis_fifo_sync #(
  // power of two, at least 2
  parameter int FIFO_DEPTH = 8
) (
  input  logic                    axis_clk,
  input  logic                    rst_n,

  // write side
  input  logic                    in_valid,
  output logic                    in_ready,
  input  axis_fan_out_pkg::data_t in_data,

  // read side, registered
  output logic                    out_valid,
  input  logic                    out_ready,
  output axis_fan_out_pkg::data_t out_data
);

  import axis_fan_out_pkg::*;

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  // extra msb tells full from empty
  typedef logic [ADDR_W:0] ptr_t;

  data_t mem [FIFO_DEPTH];
  ptr_t  wr_ptr;
  ptr_t  rd_ptr;
  logic  mem_empty;
  logic  mem_full;
  logic  wr_fire;
  // output word free or leaving this cycle
  logic  out_load;
  logic  bypass;

  //////////////////////////////////////////////////
  // status

  assign mem_empty = (wr_ptr == rd_ptr);
  assign mem_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  // when full, a read frees a slot the same cycle
  assign in_ready = ~mem_full | out_ready;
  assign wr_fire  = in_valid & in_ready;
  assign out_load = ~out_valid | out_ready;
  // empty memory, new word goes straight to output
  assign bypass   = out_load & mem_empty;

  //////////////////////////////////////////////////
  // pointers and output valid

  always_ff @(posedge axis_clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      out_valid <= 1'b0;
    end else begin
      if (wr_fire && !bypass) begin
        wr_ptr <= wr_ptr + ptr_t'(1);
      end
      if (out_load) begin
        if (!mem_empty) begin
          // oldest stored word first
          rd_ptr    <= rd_ptr + ptr_t'(1);
          out_valid <= 1'b1;
        end else begin
          out_valid <= wr_fire;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // storage

  always_ff @(posedge axis_clk) begin
    if (wr_fire && !bypass) begin
      mem[wr_ptr[ADDR_W-1:0]] <= in_data;
    end
  end

  // output word, memory head or bypassed input
  always_ff @(posedge axis_clk) begin
    if (out_load) begin
      if (!mem_empty) begin
        out_data <= mem[rd_ptr[ADDR_W-1:0]];
      end else if (wr_fire) begin
        out_data <= in_data;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/axis_lane_stats.sv
//////////////////////////////////////////////////
// output statistics
// delivered beats per lane and dropped beats,
// 16-bit wrapping counters
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module axis_lane_stats (
  input  logic                          axis_clk,
  input  logic                          rst_n,

  // observed output handshakes
  input  axis_fan_out_pkg::lane_mask_t  m_tvalid,
  input  axis_fan_out_pkg::lane_mask_t  m_tready,

  // strobe from decode
  input  logic                          drop_pulse,

  output axis_fan_out_pkg::lane_count_t lane_count,
  output axis_fan_out_pkg::count_t      drop_count
);

  import axis_fan_out_pkg::*;

  // one bit per completed transfer this cycle
  lane_mask_t lane_fire;

  assign lane_fire = m_tvalid & m_tready;

  //////////////////////////////////////////////////
  // lane counters

  // count lands one cycle after the handshake
  always_ff @(posedge axis_clk) begin
    if (!rst_n) begin
      lane_count <= '0;
    end else begin
      for (int n = 0; n < NUM_LANES; n++) begin
        if (lane_fire[n]) begin
          lane_count[n] <= lane_count[n] + count_t'(1);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // drop counter

  always_ff @(posedge axis_clk) begin
    if (!rst_n) begin
      drop_count <= '0;
    end else if (drop_pulse) begin
      // wraps silently at 16 bits
      drop_count <= drop_count + count_t'(1);
    end
  end

endmodule

`default_nettype wire

//--- verilog/axis_fan_out_top.sv
//////////////////////////////////////////////////
// fan-out subsystem top level
// decode, router, one FIFO per lane, statistics
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module axis_fan_out_top #(
  // words per lane FIFO, power of two
  parameter int FIFO_DEPTH = 8
) (
  input  logic                          axis_clk,
  input  logic                          rst_n,

  // stream in, lane in the top two bits
  input  logic                          s_tvalid,
  output logic                          s_tready,
  input  axis_fan_out_pkg::data_t       s_tdata,

  // three stream outputs
  output axis_fan_out_pkg::lane_mask_t  m_tvalid,
  input  axis_fan_out_pkg::lane_mask_t  m_tready,
  output axis_fan_out_pkg::lane_data_t  m_tdata,

  // statistics
  output axis_fan_out_pkg::lane_count_t lane_count,
  output axis_fan_out_pkg::count_t      drop_count
);

  import axis_fan_out_pkg::*;

  // decode to router
  logic       dec_valid;
  logic       dec_ready;
  axis_beat_t dec_beat;
  logic       drop_pulse;

  // router to lane FIFOs
  lane_mask_t fan_valid;
  lane_mask_t fan_ready;
  data_t      fan_data;

  //////////////////////////////////////////////////
  // producer and router

  axis_dest_decode u_decode (
    .axis_clk   (axis_clk),
    .rst_n      (rst_n),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .s_tdata    (s_tdata),
    .dec_valid  (dec_valid),
    .dec_ready  (dec_ready),
    .dec_beat   (dec_beat),
    .drop_pulse (drop_pulse)
  );

  axis_fan_out_core u_core (
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_beat  (dec_beat),
    .fan_valid (fan_valid),
    .fan_ready (fan_ready),
    .fan_data  (fan_data)
  );

  //////////////////////////////////////////////////
  // lane buffers

  // a stalled lane only blocks once its FIFO fills
  for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
    axis_fifo_sync #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
      .axis_clk  (axis_clk),
      .rst_n     (rst_n),
      .in_valid  (fan_valid[n]),
      .in_ready  (fan_ready[n]),
      .in_data   (fan_data),
      .out_valid (m_tvalid[n]),
      .out_ready (m_tready[n]),
      .out_data  (m_tdata[n])
    );
  end

  // counts what actually leaves the outputs
  axis_lane_stats u_stats (
    .axis_clk   (axis_clk),
    .rst_n      (rst_n),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .drop_pulse (drop_pulse),
    .lane_count (lane_count),
    .drop_count (drop_count)
  );

endmodule

`default_nettype wire

//--- test/axis_fan_out_tb.sv
//////////////////////////////////////////////////
// testbench for the fan-out subsystem
// stimulus table, per-lane scoreboards, random
// output back-pressure, stats checks, watchdog
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module axis_fan_out_tb;

  import axis_fan_out_pkg::*;

  //////////////////////////////////////////////////
  // stimulus table

  // back-pressure modes on m_tready
  localparam logic [1:0] MODE_ALL   = 2'd0;
  localparam logic [1:0] MODE_HOLD1 = 2'd1;
  localparam logic [1:0] MODE_RAND  = 2'd2;

  typedef struct packed {
    data_t      word;
    logic [1:0] mode;
  } stim_t;

  localparam int NUM_STIM       = 24;
  localparam int TIMEOUT_CYCLES = 20 * NUM_STIM + 200;

  // lane is the top two bits, 3 means drop
  localparam stim_t STIM [NUM_STIM] = '{
    '{32'h0000_0a01, MODE_ALL},   '{32'h4000_0b02, MODE_ALL},
    '{32'h8000_0c03, MODE_ALL},   '{32'hc000_0d04, MODE_ALL},
    '{32'h3fff_fff0, MODE_ALL},   '{32'hbfff_ffff, MODE_ALL},
    '{32'h4000_0b07, MODE_ALL},   '{32'hc000_0d08, MODE_ALL},
    // lane 1 stalled, others keep flowing
    '{32'h4000_1b11, MODE_HOLD1}, '{32'h0000_1a12, MODE_HOLD1},
    '{32'h4000_1b13, MODE_HOLD1}, '{32'h8000_1c14, MODE_HOLD1},
    '{32'h4000_1b15, MODE_HOLD1}, '{32'hc000_1d16, MODE_HOLD1},
    '{32'h0000_1a17, MODE_HOLD1}, '{32'h8000_1c18, MODE_HOLD1},
    // random ready on every lane
    '{32'h0000_2a21, MODE_RAND},  '{32'h4000_2b22, MODE_RAND},
    '{32'h8000_2c23, MODE_RAND},  '{32'h4000_2b24, MODE_RAND},
    '{32'hc000_2d25, MODE_RAND},  '{32'h0000_2a26, MODE_RAND},
    '{32'h8000_2c27, MODE_RAND},  '{32'h4000_2b28, MODE_RAND}
  };

  //////////////////////////////////////////////////
  // DUT and scoreboard state

  logic        axis_clk;
  logic        rst_n;
  logic        s_tvalid;
  logic        s_tready;
  data_t       s_tdata;
  lane_mask_t  m_tvalid;
  lane_mask_t  m_tready;
  lane_data_t  m_tdata;
  lane_count_t lane_count;
  count_t      drop_count;

  data_t       exp_q [NUM_LANES][$];
  int          exp_total [NUM_LANES] = '{default: 0};
  int          exp_drops = 0;
  int          checks = 0;
  int          errors = 0;
  int          cycle_cnt = 0;
  logic [1:0]  ready_mode;
  logic [31:0] rng_state = 32'd5;

  axis_fan_out_top #(
    .FIFO_DEPTH (4)
  ) dut (
    .axis_clk   (axis_clk),
    .rst_n      (rst_n),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .s_tdata    (s_tdata),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tdata    (m_tdata),
    .lane_count (lane_count),
    .drop_count (drop_count)
  );

  // 8 ns period
  initial begin
    axis_clk = 1'b0;
    forever #4 axis_clk = ~axis_clk;
  end

  //////////////////////////////////////////////////
  // compare tasks and helpers

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_mask(input string name, input lane_mask_t got,
                            input lane_mask_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // 32-bit xorshift, shifts 13/17/5
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic bit lanes_pending(input lane_mask_t which);
    for (int n = 0; n < NUM_LANES; n++) begin
      if (which[n] && exp_q[n].size() != 0) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge axis_clk);
    #1;
    case (ready_mode)
      MODE_ALL:   m_tready = '1;
      MODE_HOLD1: m_tready = lane_mask_t'(3'b101);
      default: begin
        rng_state = xorshift32(rng_state);
        m_tready  = rng_state[2:0];
      end
    endcase
  endtask

  // hold the word until s_tready seen, then log it
  task automatic send_word(input data_t word);
    logic  taken;
    dest_t lane;
    s_tvalid = 1'b1;
    s_tdata  = word;
    taken    = 1'b0;
    while (!taken) begin
      // stable mid-cycle, transfer on the next edge
      @(negedge axis_clk);
      taken = s_tready;
      next_cycle();
    end
    s_tvalid = 1'b0;
    lane = word[DATA_WIDTH-1 -: DEST_WIDTH];
    if (lane == dest_t'(3)) begin
      exp_drops++;
    end else begin
      exp_q[lane].push_back(word);
      exp_total[lane]++;
    end
  endtask

  task automatic wait_lanes(input lane_mask_t which, input int limit, input string what);
    int waited;
    waited = 0;
    while (lanes_pending(which) && waited < limit) begin
      next_cycle();
      waited++;
    end
    checks++;
    if (lanes_pending(which)) begin
      errors++;
      $display("%s still have words pending after %0d cycles", what, limit);
    end
  endtask

  // lanes 0 and 2 drain while lane 1 stays stalled
  task automatic check_isolation();
    wait_lanes(lane_mask_t'(3'b101), 100, "lanes 0 and 2 behind stalled lane 1");
    check_mask("m_tvalid lane 1", m_tvalid & lane_mask_t'(3'b010), lane_mask_t'(3'b010));
    // held lane still shows its oldest word
    check_data("m_tdata[1] held", m_tdata[1], exp_q[1][0]);
  endtask

  task automatic check_stats();
    for (int n = 0; n < NUM_LANES; n++) begin
      check_count($sformatf("lane_count[%0d]", n), lane_count[n], count_t'(exp_total[n]));
    end
    check_count("drop_count", drop_count, count_t'(exp_drops));
  endtask

  //////////////////////////////////////////////////
  // output monitor

  // handshake seen mid-cycle completes on the next edge
  always @(negedge axis_clk) begin
    if (rst_n) begin
      for (int n = 0; n < NUM_LANES; n++) begin
        if (m_tvalid[n] && m_tready[n]) begin
          if (exp_q[n].size() == 0) begin
            errors++;
            $display("unexpected word %h on lane %0d at %0t", m_tdata[n], n, $time);
          end else begin
            check_data($sformatf("m_tdata[%0d]", n), m_tdata[n], exp_q[n].pop_front());
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // watchdog

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge axis_clk);
      cycle_cnt++;
    end
    $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    rst_n      = 1'b0;
    s_tvalid   = 1'b0;
    s_tdata    = '0;
    m_tready   = '0;
    ready_mode = MODE_ALL;
    repeat (4) @(posedge axis_clk);
    #1;
    rst_n = 1'b1;
    // reset state, nothing sent yet so totals are zero
    check_mask("m_tvalid", m_tvalid, '0);
    check_stats();
    next_cycle();
    for (int i = 0; i < NUM_STIM; i++) begin
      if (i > 0 && STIM[i-1].mode == MODE_HOLD1 && STIM[i].mode != MODE_HOLD1) begin
        check_isolation();
      end
      ready_mode = STIM[i].mode;
      send_word(STIM[i].word);
    end
    wait_lanes('1, 200, "output lanes");
    // let the stats counters settle
    ready_mode = MODE_ALL;
    repeat (3) next_cycle();
    check_stats();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- axis_fan_out.f
verilog/axis_fan_out_pkg.sv
verilog/axis_dest_decode.sv
verilog/axis_fan_out_core.sv
verilog/axis_fifo_sync.sv
verilog/axis_lane_stats.sv
verilog/axis_fan_out_top.sv
test/axis_fan_out_tb.sv

//--- Makefile
# Verilator build and run for the axis_fan_out subsystem
# any variable below can be set on the command line

VERILATOR ?= verilator
TOP       ?= axis_fan_out_tb
FILELIST  ?= axis_fan_out.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# fails unless the run prints the pass line
test: $(BUILD_DIR)/$(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)
